// ==== tb.f ====
+incdir+design
+incdir+verif
design/rv_nibble_pkg.sv
design/nibble_alu.sv
design/shift_loop.sv
design/register_file.sv
design/ram.sv
design/control.sv
design/rv_nibble_core.sv
verif/tb_rv_nibble_core.sv

// ==== Bender.yml ====
package:
  name: rv_nibble_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_nibble_pkg.sv
      - design/nibble_alu.sv
      - design/shift_loop.sv
      - design/register_file.sv
      - design/ram.sv
      - design/control.sv
      - design/rv_nibble_core.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/tb_rv_nibble_core.sv

// ==== verif/tb_iss_model.svh ====
// reference ISA model with its own architectural state
logic [31:0] iss_regs [32];
logic [31:0] iss_mem [`RV_RAM_WORDS];
logic [31:0] iss_pc;

// runs the word at iss_pc and returns 1 when it is legal
// an illegal word leaves every register, memory word and the pc untouched
function automatic logic iss_step(output retire_t rec);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] ea;
    logic        wr;
    logic        ok;
    ins   = iss_mem[(iss_pc >> 2) % `RV_RAM_WORDS];
    a     = iss_regs[ins[19:15]];
    b     = iss_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    rec   = '0;
    rec.pc      = iss_pc;
    rec.next_pc = iss_pc + 32'd4;
    res = '0;
    ea  = '0;
    wr  = 1'b1;
    ok  = 1'b1;
    case (ins[6:0])
        7'b0010011: begin
            case (ins[14:12])
                3'b000:  res = a + imm_i;
                3'b100:  res = a ^ imm_i;
                3'b110:  res = a | imm_i;
                3'b111:  res = a & imm_i;
                3'b001:  res = a << ins[24:20];
                3'b101:  res = a >> ins[24:20];
                default: ok = 1'b0;
            endcase
            // shifts need a zero funct7, srai is not supported
            if (ins[13:12] == 2'b01 && ins[31:25] != 7'b0) ok = 1'b0;
        end
        7'b0110011: begin
            case ({ins[31:25], ins[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_100: res = a ^ b;
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         ok = 1'b0;
            endcase
        end
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b0010111: res = iss_pc + {ins[31:12], 12'b0};
        7'b0000011: begin
            ea  = a + imm_i;
            res = iss_mem[(ea >> 2) % `RV_RAM_WORDS];
            ok  = (ins[14:12] == 3'b010);
        end
        7'b0100011: begin
            ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            wr = 1'b0;
            ok = (ins[14:12] == 3'b010);
            rec.mem_we    = 1'b1;
            rec.mem_addr  = ea;
            rec.mem_wdata = b;
        end
        7'b1101111: begin
            // link value is the fall-through pc
            res = iss_pc + 32'd4;
            rec.next_pc = iss_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'b1100011: begin
            wr = 1'b0;
            ok = (ins[14:12] == 3'b000);
            if (a == b) rec.next_pc = iss_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                                ins[11:8], 1'b0};
        end
        default: ok = 1'b0;
    endcase
    if (ok) begin
        if (wr) begin
            rec.rd_we   = 1'b1;
            rec.rd      = ins[11:7];
            rec.rd_data = res;
            if (ins[11:7] != 5'd0) iss_regs[ins[11:7]] = res;
        end
        if (rec.mem_we) iss_mem[(ea >> 2) % `RV_RAM_WORDS] = b;
        iss_pc = rec.next_pc;
    end
    return ok;
endfunction

// ==== verif/tb_rv_nibble_core.sv ====
`timescale 1ns/1ps
`include "rv_nibble_config.svh"

module tb_rv_nibble_core
    import rv_nibble_pkg::*;
();

    localparam int N_INSTR        = 200;
    // data area sits above the program, reachable from x0 with a positive offset
    localparam int DATA_BASE      = 32'h600;
    localparam int DATA_WORDS     = 16;
    localparam int TIMEOUT_CYCLES = N_INSTR * 60 + 1000;

    logic        clk;
    logic        rst_n;
    prog_write_t prog;
    logic        start;
    logic        retire_valid;
    retire_t     retire;
    logic        error;
    logic        running;

    logic [31:0] lfsr;
    logic [31:0] image_addr [$];
    logic [31:0] image_data [$];
    int          cycles;
    int          retired;

    `include "tb_iss_model.svh"

    rv_nibble_core i_dut (
        .clk, .rst_n, .prog, .start,
        .retire_valid, .retire, .error, .running
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit, counted from time zero
    initial cycles = 0;
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout, the core did not reach the trap word in %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "simulation timeout");
        end
    end

    // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // one random instruction from the supported set
    function automatic logic [31:0] gen_instr(input int idx);
        logic [4:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [11:0] off;
        logic [4:0]  br;
        kind  = 5'(rand_bits(5) % 17);
        rd    = 5'(rand_bits(4) % 15 + 1);
        rs1   = 5'(rand_bits(4));
        // equal sources half the time so beq is often taken
        rs2   = rand_bits(1) ? rs1 : 5'(rand_bits(4));
        imm   = 12'(rand_bits(12));
        upper = 20'(rand_bits(20));
        off   = 12'(DATA_BASE + 4 * rand_bits(4));
        // the last slot steps by 4 so the trap word is never jumped over
        br    = (rand_bits(1) && idx != N_INSTR - 1) ? 5'd8 : 5'd4;
        case (kind)
            5'd0:    return {imm, rs1, 3'b000, rd, 7'b0010011};
            5'd1:    return {imm, rs1, 3'b111, rd, 7'b0010011};
            5'd2:    return {imm, rs1, 3'b110, rd, 7'b0010011};
            5'd3:    return {imm, rs1, 3'b100, rd, 7'b0010011};
            5'd4:    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            5'd5:    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            5'd6:    return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            5'd7:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            5'd8:    return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            // slli and srli, shamt 0 to 31
            5'd9:    return {7'b0000000, imm[4:0], rs1, 3'b001, rd, 7'b0010011};
            5'd10:   return {7'b0000000, imm[4:0], rs1, 3'b101, rd, 7'b0010011};
            5'd11:   return {upper, rd, 7'b0110111};
            5'd12:   return {upper, rd, 7'b0010111};
            5'd13:   return {off, 5'd0, 3'b010, rd, 7'b0000011};
            5'd14:   return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
            5'd15:   return {1'b0, 6'b0, br[4:1], 1'b0, 8'b0, rd, 7'b1101111};
            default: return {7'b0, rs2, rs1, 3'b000, br[4:1], 1'b0, 7'b1100011};
        endcase
    endfunction

    // model steps once per retire, every field must agree
    task automatic compare_retire();
        retire_t exp;
        logic    legal;
        legal = iss_step(exp);
        check_value("model_legal", 32'(legal), 32'd1);
        check_value("retire.pc", retire.pc, exp.pc);
        check_value("retire.next_pc", retire.next_pc, exp.next_pc);
        check_value("retire.rd", 32'(retire.rd), 32'(exp.rd));
        check_value("retire.rd_data", retire.rd_data, exp.rd_data);
        check_value("retire.rd_we", 32'(retire.rd_we), 32'(exp.rd_we));
        check_value("retire.mem_we", 32'(retire.mem_we), 32'(exp.mem_we));
        check_value("retire.mem_addr", retire.mem_addr, exp.mem_addr);
        check_value("retire.mem_wdata", retire.mem_wdata, exp.mem_wdata);
        retired++;
    endtask

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        prog    = '0;
        lfsr    = 32'h1226_af77;
        retired = 0;
        for (int r = 0; r < 32; r++) iss_regs[r] = '0;
        // program, trap word, then preloaded data area
        for (int i = 0; i < N_INSTR; i++) begin
            image_addr.push_back(`RV_START_ADDR + 4 * i);
            image_data.push_back(gen_instr(i));
        end
        image_addr.push_back(`RV_START_ADDR + 4 * N_INSTR);
        image_data.push_back(32'h0000_0000);
        for (int i = 0; i < DATA_WORDS; i++) begin
            image_addr.push_back(DATA_BASE + 4 * i);
            image_data.push_back(rand_bits(32));
        end

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("error", 32'(error), 32'd0);
        check_value("running", 32'(running), 32'd0);

        // load while idle, nothing may retire yet
        for (int i = 0; i < image_addr.size(); i++) begin
            @(negedge clk);
            check_value("retire_valid", 32'(retire_valid), 32'd0);
            prog = '{en: 1'b1, addr: image_addr[i], data: image_data[i]};
        end
        @(negedge clk);
        prog = '0;
        for (int i = 0; i < image_addr.size(); i++) begin
            iss_mem[(image_addr[i] >> 2) % `RV_RAM_WORDS] = image_data[i];
        end
        iss_pc = `RV_START_ADDR;

        @(negedge clk);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("running", 32'(running), 32'd1);

        do begin
            @(negedge clk);
            if (retire_valid) compare_retire();
        end while (!error);

        // the model must also stand on the trap word
        check_value("iss_pc", iss_pc, `RV_START_ADDR + 4 * N_INSTR);
        repeat (50) begin
            @(negedge clk);
            check_value("retire_valid", 32'(retire_valid), 32'd0);
            check_value("error", 32'(error), 32'd1);
            check_value("running", 32'(running), 32'd0);
        end
        $display("retired %0d instructions", retired);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== design/rv_nibble_core.sv ====
`timescale 1ns/1ps

module rv_nibble_core
    import rv_nibble_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  prog_write_t prog,
    input  logic        start,
    output logic        retire_valid,
    output retire_t     retire,
    output logic        error,
    output logic        running
);

    alu_req_t    alu_req;
    logic        alu_go, alu_done, alu_zero;
    logic [31:0] alu_result;
    logic [31:0] shift_value, shift_result;
    logic [4:0]  shift_amount;
    logic        shift_left, shift_go, shift_done;
    logic [4:0]  rs1_addr, rs2_addr, rd_addr;
    logic [31:0] rs1_data, rs2_data, rd_data;
    logic        rd_we;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic        mem_we;
    prog_write_t prog_ram;

    // program load only takes effect while the core is stopped
    assign prog_ram = '{en: prog.en && !running, addr: prog.addr, data: prog.data};

    control u_control (
        .clk, .rst_n, .start,
        .instr(mem_rdata), .rdata(mem_rdata),
        .rs1_data, .rs2_data,
        .alu_result, .alu_done, .alu_zero,
        .shift_result, .shift_done,
        .alu_req, .alu_go,
        .shift_value, .shift_amount, .shift_left, .shift_go,
        .rs1_addr, .rs2_addr, .rd_addr, .rd_we, .rd_data,
        .mem_addr, .mem_we, .mem_wdata,
        .retire_valid, .retire, .error, .running
    );

    nibble_alu u_alu (
        .clk, .rst_n, .req(alu_req), .go(alu_go),
        .busy(), .done(alu_done), .result(alu_result), .zero(alu_zero)
    );

    shift_loop u_shift (
        .clk, .rst_n, .value(shift_value), .amount(shift_amount),
        .left(shift_left), .go(shift_go),
        .busy(), .done(shift_done), .result(shift_result)
    );

    register_file u_regs (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rd_addr, .rd_we, .rd_data,
        .rs1_data, .rs2_data
    );

    ram u_ram (
        .clk, .prog(prog_ram), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

endmodule

// ==== design/control.sv ====
`timescale 1ns/1ps
`include "rv_nibble_config.svh"

module control
    import rv_nibble_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [31:0] instr,
    input  logic [31:0] rdata,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] alu_result,
    input  logic        alu_done,
    input  logic        alu_zero,
    input  logic [31:0] shift_result,
    input  logic        shift_done,
    output alu_req_t    alu_req,
    output logic        alu_go,
    output logic [31:0] shift_value,
    output logic [4:0]  shift_amount,
    output logic        shift_left,
    output logic        shift_go,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output logic        rd_we,
    output logic [31:0] rd_data,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    output logic        retire_valid,
    output retire_t     retire,
    output logic        error,
    output logic        running
);

    state_e       state;
    logic [31:0]  pc, ir, cur, addr_q, res_q, next_pc_q;
    logic         pass2, taken;
    instr_class_e cls;
    alu_op_e      dec_op;
    logic [31:0]  imm_i, imm_s, imm_b, imm_u, imm_j;
    logic         needs2, uses_alu, writes_rd, launch2, exec_done;

    function automatic alu_op_e f3_op(input logic [2:0] f3);
        case (f3)
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // fresh RAM word while decoding, latched copy afterwards
    assign cur   = (state == DECODE) ? instr : ir;
    assign imm_i = {{20{cur[31]}}, cur[31:20]};
    assign imm_s = {{20{cur[31]}}, cur[31:25], cur[11:7]};
    assign imm_b = {{19{cur[31]}}, cur[31], cur[7], cur[30:25], cur[11:8], 1'b0};
    assign imm_u = {cur[31:12], 12'b0};
    assign imm_j = {{11{cur[31]}}, cur[31], cur[19:12], cur[20], cur[30:21], 1'b0};

    // class decode, anything unlisted is illegal
    always_comb begin
        cls    = CL_ILLEGAL;
        dec_op = f3_op(cur[14:12]);
        case (cur[6:0])
            OPC_OP_IMM: begin
                if (cur[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111}) cls = CL_ALU_IMM;
                else if (cur[13:12] == 2'b01 && cur[31:25] == 7'b0) cls = CL_SHIFT;
            end
            OPC_OP: begin
                if (cur[31:25] == 7'b0 && cur[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111})
                    cls = CL_ALU_REG;
                else if (cur[31:25] == 7'b0100000 && cur[14:12] == 3'b000) begin
                    cls    = CL_ALU_REG;
                    dec_op = ALU_SUB;
                end
            end
            OPC_LUI:    cls = CL_LUI;
            OPC_AUIPC:  cls = CL_AUIPC;
            OPC_LOAD:   if (cur[14:12] == 3'b010) cls = CL_LOAD;
            OPC_STORE:  if (cur[14:12] == 3'b010) cls = CL_STORE;
            OPC_JAL:    cls = CL_JAL;
            OPC_BRANCH: if (cur[14:12] == 3'b000) cls = CL_BEQ;
            default:    cls = CL_ILLEGAL;
        endcase
    end

    assign needs2    = (cls == CL_JAL) || (cls == CL_BEQ);
    assign uses_alu  = !(cls inside {CL_ILLEGAL, CL_LUI, CL_SHIFT});
    assign writes_rd = !(cls inside {CL_ILLEGAL, CL_STORE, CL_BEQ});
    // jal and beq chain a second pass off the first done
    assign launch2   = (state == EXEC) && alu_done && needs2 && !pass2;
    assign exec_done = (cls == CL_SHIFT) ? shift_done : (alu_done && (!needs2 || pass2));

    // first pass issued from DECODE, second pass from EXEC
    always_comb begin
        alu_req = '{a: rs1_data, b: imm_i, op: dec_op};
        if (state == EXEC) begin
            alu_req = '{a: pc, b: (cls == CL_JAL) ? 32'd4 : imm_b, op: ALU_ADD};
        end else begin
            case (cls)
                CL_ALU_REG: alu_req.b = rs2_data;
                CL_AUIPC:   alu_req = '{a: pc, b: imm_u, op: ALU_ADD};
                CL_LOAD:    alu_req.op = ALU_ADD;
                CL_STORE:   alu_req = '{a: rs1_data, b: imm_s, op: ALU_ADD};
                CL_JAL:     alu_req = '{a: pc, b: imm_j, op: ALU_ADD};
                CL_BEQ:     alu_req = '{a: rs1_data, b: rs2_data, op: ALU_SUB};
                default:    alu_req.op = dec_op;
            endcase
        end
    end

    assign alu_go       = ((state == DECODE) && uses_alu) || launch2;
    assign shift_go     = (state == DECODE) && (cls == CL_SHIFT);
    assign shift_value  = rs1_data;
    assign shift_amount = cur[24:20];
    assign shift_left   = (cur[14:12] == 3'b001);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= '0;
            pass2 <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    pc    <= `RV_START_ADDR;
                    state <= FETCH;
                end
                FETCH: state <= DECODE;
                DECODE: begin
                    pass2 <= 1'b0;
                    if (cls == CL_ILLEGAL) state <= ERROR;
                    else if (cls == CL_LUI) state <= WRITEBACK;
                    else state <= EXEC;
                end
                EXEC: begin
                    if (launch2) pass2 <= 1'b1;
                    else if (exec_done) state <= (cls inside {CL_LOAD, CL_STORE}) ? MEM : WRITEBACK;
                end
                MEM: state <= WRITEBACK;
                WRITEBACK: begin
                    pc    <= next_pc_q;
                    state <= FETCH;
                end
                default: state <= ERROR;
            endcase
        end
    end

    // lui value and fall-through pc preset in DECODE, EXEC overwrites
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir        <= instr;
            res_q     <= imm_u;
            next_pc_q <= pc + 32'd4;
        end else if (state == EXEC && cls == CL_SHIFT && shift_done) begin
            res_q <= shift_result;
        end else if (state == EXEC && alu_done) begin
            case (cls)
                CL_JAL:   if (!pass2) next_pc_q <= alu_result; else res_q <= alu_result;
                CL_BEQ:   if (!pass2) taken <= alu_zero; else if (taken) next_pc_q <= alu_result;
                CL_LOAD,
                CL_STORE: addr_q <= alu_result;
                default:  res_q <= alu_result;
            endcase
        end
    end

    assign rs1_addr  = cur[19:15];
    assign rs2_addr  = cur[24:20];
    assign rd_addr   = cur[11:7];
    // load data arrives the cycle after MEM
    assign rd_data   = (cls == CL_LOAD) ? rdata : res_q;
    assign rd_we     = (state == WRITEBACK) && writes_rd;
    assign mem_addr  = (state == MEM) ? addr_q : pc;
    assign mem_we    = (state == MEM) && (cls == CL_STORE);
    assign mem_wdata = rs2_data;

    assign retire_valid = (state == WRITEBACK);
    assign retire = '{pc: pc, next_pc: next_pc_q,
                      rd: writes_rd ? rd_addr : 5'd0,
                      rd_data: writes_rd ? rd_data : 32'd0,
                      rd_we: writes_rd, mem_we: (cls == CL_STORE),
                      mem_addr: (cls == CL_STORE) ? addr_q : 32'd0,
                      mem_wdata: (cls == CL_STORE) ? rs2_data : 32'd0};
    assign error   = (state == ERROR);
    assign running = (state != IDLE) && (state != ERROR);

    // once stopped, the core stays stopped and retires nothing
    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        error |=> error && !retire_valid);
    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> mem_addr[1:0] == 2'b00);

endmodule

// ==== design/ram.sv ====
`timescale 1ns/1ps
`include "rv_nibble_config.svh"

module ram
    import rv_nibble_pkg::*;
(
    input  logic        clk,
    input  prog_write_t prog,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(`RV_RAM_WORDS);

    logic [31:0]   mem [`RV_RAM_WORDS];
    logic [AW-1:0] idx;
    logic [AW-1:0] prog_idx;

    // word index, byte offset dropped, upper bits wrap
    assign idx      = addr[AW+1:2];
    assign prog_idx = prog.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (prog.en) begin
            mem[prog_idx] <= prog.data;
        end else if (we) begin
            mem[idx] <= wdata;
        end
        // registered read, old data on a same-cycle write
        rdata <= mem[idx];
    end

    // program load and core store are never live together
    a_one_writer: assert property (@(posedge clk) !(prog.en && we));

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic        rd_we,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0][31:0] regs;

    // all registers clear on reset, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // combinational reads
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

// ==== design/shift_loop.sv ====
`timescale 1ns/1ps

module shift_loop (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] value,
    input  logic [4:0]  amount,
    input  logic        left,
    input  logic        go,
    output logic        busy,
    output logic        done,
    output logic [31:0] result
);

    logic [4:0]  cnt;
    logic [31:0] val;
    logic        left_q;

    // remaining bit positions, done once it reaches zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (go) begin
            busy <= 1'b1;
            cnt  <= amount;
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // one bit per cycle, zero fill on both sides
    always_ff @(posedge clk) begin
        if (go) begin
            val    <= value;
            left_q <= left;
        end else if (busy && cnt != '0) begin
            val <= left_q ? (val << 1) : (val >> 1);
        end
    end

    assign done   = busy && (cnt == '0);
    assign result = val;

endmodule

// ==== design/nibble_alu.sv ====
`timescale 1ns/1ps
`include "rv_nibble_config.svh"

module nibble_alu
    import rv_nibble_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  alu_req_t    req,
    input  logic        go,
    output logic        busy,
    output logic        done,
    output logic [31:0] result,
    output logic        zero
);

    localparam int CNT_W = $clog2(`RV_ALU_STEPS);

    logic [CNT_W-1:0] step;
    logic [31:0]      a_sh;
    logic [31:0]      b_sh;
    logic [31:0]      acc;
    alu_op_e          op_q;
    logic             carry;
    logic             nz;
    logic [4:0]       sum;
    logic [3:0]       nib;

    // one nibble slice, b already inverted for subtract
    always_comb begin
        sum = {1'b0, a_sh[3:0]} + {1'b0, b_sh[3:0]} + {4'b0, carry};
        case (op_q)
            ALU_AND: nib = a_sh[3:0] & b_sh[3:0];
            ALU_OR:  nib = a_sh[3:0] | b_sh[3:0];
            ALU_XOR: nib = a_sh[3:0] ^ b_sh[3:0];
            default: nib = sum[3:0];
        endcase
    end

    // step counter, busy for exactly RV_ALU_STEPS cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == CNT_W'(`RV_ALU_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // operands rotate down, result nibbles enter from the top
    always_ff @(posedge clk) begin
        if (go) begin
            a_sh  <= req.a;
            b_sh  <= (req.op == ALU_SUB) ? ~req.b : req.b;
            op_q  <= req.op;
            // two's complement carry-in
            carry <= (req.op == ALU_SUB);
            nz    <= 1'b0;
        end else if (busy) begin
            a_sh  <= a_sh >> 4;
            b_sh  <= b_sh >> 4;
            acc   <= {nib, acc[31:4]};
            carry <= sum[4];
            nz    <= nz | (|nib);
        end
    end

    assign result = acc;
    assign zero   = ~nz;

    // a new request only once the previous one has finished
    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n) go |-> !busy);

endmodule

// ==== design/rv_nibble_pkg.sv ====
package rv_nibble_pkg;

    // major opcodes of the supported RV32I subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WRITEBACK,
        ERROR
    } state_e;

    // nibble ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // instruction classes after decode
    typedef enum logic [3:0] {
        CL_ILLEGAL,
        CL_ALU_IMM,
        CL_ALU_REG,
        CL_SHIFT,
        CL_LUI,
        CL_AUIPC,
        CL_LOAD,
        CL_STORE,
        CL_JAL,
        CL_BEQ
    } instr_class_e;

    // one ALU request, latched by the ALU on go
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        alu_op_e     op;
    } alu_req_t;

    // program load strobe into the RAM, byte address
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] data;
    } prog_write_t;

    // retire record, valid with retire_valid
    // rd fields and mem fields are zero when the matching enable is low
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        rd_we;
        logic        mem_we;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
    } retire_t;

endpackage

// ==== design/rv_nibble_config.svh ====
`ifndef RV_NIBBLE_CONFIG_SVH
`define RV_NIBBLE_CONFIG_SVH

// first fetch address after start, one full word
`define RV_START_ADDR 32'h0000_0100

// number of 32-bit words in the RAM
// must stay a power of two, the index drops the upper address bits
`define RV_RAM_WORDS 1024

// nibble steps per ALU operation
// 8 nibbles cover one 32-bit word
`define RV_ALU_STEPS 8

`endif
